// File: hdl/dct_arith_pkg.sv
// ----------------------------------------------------------------------
// DCT arithmetic definitions
// sample type, Q12 fixed-point format, cosine constants and the
// rounding multiply shared by the butterfly stages
// ----------------------------------------------------------------------

package dct_arith_pkg;

    localparam int data_width = 18;
    localparam int frac_bits  = 12;

    typedef logic signed [data_width-1:0] calc_t;

    // sqrt(2) * cos(i*pi/16), Q12, rounded to nearest
    localparam calc_t coef_r0 = 18'sd5793;
    localparam calc_t coef_r1 = 18'sd5681;
    localparam calc_t coef_r2 = 18'sd5352;
    localparam calc_t coef_r3 = 18'sd4816;
    localparam calc_t coef_r4 = 18'sd4096;
    localparam calc_t coef_r5 = 18'sd3218;
    localparam calc_t coef_r6 = 18'sd2217;
    localparam calc_t coef_r7 = 18'sd1130;

    // 1/sqrt(2) and 0.5/sqrt(2)
    localparam calc_t coef_rsqrt2      = 18'sd2896;
    localparam calc_t coef_rsqrt2_half = 18'sd1448;

    function automatic calc_t mul_round(input calc_t a, input calc_t b);
        logic signed [2*data_width-1:0] prod;
        prod = a * b;
        prod = prod + (36'sd1 <<< (frac_bits - 1));
        return calc_t'(prod >>> frac_bits);
    endfunction

endpackage

// File: hdl/dct_sched_pkg.sv
// ----------------------------------------------------------------------
// DCT schedule definitions
// per-stage read orders, index remaps and butterfly opcodes
// ----------------------------------------------------------------------

package dct_sched_pkg;

    typedef logic [2:0] idx_t;

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_pass,
        op_mul_add
    } bfly_op_t;

    // read orders, one entry per cycle of a block
    localparam idx_t fetch_order  [8] = '{3'd0, 3'd7, 3'd1, 3'd6, 3'd2, 3'd5, 3'd3, 3'd4};
    localparam idx_t even_order   [8] = '{3'd0, 3'd3, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
    localparam idx_t rotate_order [8] = '{3'd1, 3'd0, 3'd2, 3'd3, 3'd7, 3'd4, 3'd5, 3'd6};
    localparam idx_t final_order  [8] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd7, 3'd5, 3'd4, 3'd6};

    // write index, looked up by read address
    localparam idx_t rotate_remap [8] = '{3'd1, 3'd0, 3'd2, 3'd3, 3'd7, 3'd6, 3'd5, 3'd4};
    localparam idx_t final_remap  [8] = '{3'd0, 3'd4, 3'd2, 3'd6, 3'd1, 3'd3, 3'd7, 3'd5};

endpackage

// File: hdl/dct_buf_if.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// DCT inter-stage buffer interface
// write side from the producing stage, read side to the consumer
// ----------------------------------------------------------------------

interface dct_buf_if
    import dct_arith_pkg::*, dct_sched_pkg::*;
();

    logic  wr_en;
    logic  wr_last;
    idx_t  wr_idx;
    calc_t wr_data;
    idx_t  rd_idx;
    calc_t rd_data;
    logic  blk_ready;

    modport writer (output wr_en, wr_last, wr_idx, wr_data);
    modport buffer (input wr_en, wr_last, wr_idx, wr_data, rd_idx, output rd_data, blk_ready);
    modport reader (output rd_idx, input rd_data, blk_ready);

endinterface

// File: hdl/dct_pingpong_buf.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// DCT ping-pong buffer
// 16-word two-bank memory; a last write swaps the banks and
// flags the finished block to the reading stage
// ----------------------------------------------------------------------

module dct_pingpong_buf
    import dct_arith_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    dct_buf_if.buffer bif
);

    calc_t mem [16];
    logic  wr_bank;
    logic  rd_bank;

    assign bif.blk_ready = bif.wr_en && bif.wr_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
        end else if (bif.blk_ready) begin
            rd_bank <= wr_bank;
            wr_bank <= !wr_bank;
        end
    end

    // registered read, data one cycle after rd_idx
    always_ff @(posedge clk) begin
        if (bif.wr_en) begin
            mem[{wr_bank, bif.wr_idx}] <= bif.wr_data;
        end
        bif.rd_data <= mem[{rd_bank, bif.rd_idx}];
    end

endmodule

// File: hdl/dct_stage_fetch.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// DCT stage 0
// reads eight samples from the input memory in mirrored pairs and
// writes their sums and differences to the first buffer
// ----------------------------------------------------------------------

module dct_stage_fetch
    import dct_arith_pkg::*, dct_sched_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    output logic      ready,
    output logic      in_re,
    output idx_t      in_addr,
    input  calc_t     in_rdata,
    dct_buf_if.writer wr
);

    logic       rd_valid;
    logic [2:0] rd_pos;
    logic       rd_last;
    logic [3:1] vld;
    logic [3:1] lst;
    idx_t       idx [1:3];
    calc_t      smp_cur;
    calc_t      smp_prev;
    calc_t      bfly;

    assign rd_last = rd_pos == 3'd7;
    assign ready   = !rd_valid || rd_last;
    assign in_re   = rd_valid;
    assign in_addr = fetch_order[rd_pos];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_pos   <= 3'd0;
            vld      <= '0;
            lst      <= '0;
        end else begin
            if (ready) begin
                rd_valid <= start;
                rd_pos   <= 3'd0;
            end else begin
                rd_pos <= rd_pos + 3'd1;
            end
            vld <= {vld[2:1], rd_valid};
            lst <= {lst[2:1], rd_last};
        end
    end

    always_ff @(posedge clk) begin
        idx[1]   <= in_addr;
        idx[2]   <= idx[1];
        idx[3]   <= idx[2];
        smp_cur  <= in_rdata;
        smp_prev <= smp_cur;
        // low index opens a pair, its mirror closes it
        if (idx[2][2] == 1'b0) begin
            bfly <= smp_cur + in_rdata;
        end else begin
            bfly <= smp_prev - smp_cur;
        end
    end

    assign wr.wr_en   = vld[3];
    assign wr.wr_last = lst[3];
    assign wr.wr_idx  = idx[3];
    assign wr.wr_data = bfly;

endmodule

// File: hdl/dct_stage_even.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// DCT stage 1
// second butterfly level on the even half, odd half passed through
// ----------------------------------------------------------------------

module dct_stage_even
    import dct_arith_pkg::*, dct_sched_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    dct_buf_if.reader rd,
    dct_buf_if.writer wr
);

    logic       rd_valid;
    logic [2:0] rd_pos;
    logic       rd_last;
    logic [3:1] vld;
    logic [3:1] lst;
    idx_t       idx [1:3];
    calc_t      cur;
    calc_t      prev;
    calc_t      bfly;
    bfly_op_t   op;

    assign rd_last   = rd_pos == 3'd7;
    assign rd.rd_idx = even_order[rd_pos];
    assign op        = idx[2][2] ? op_pass : (idx[2][1] ? op_sub : op_add);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_pos   <= 3'd0;
            vld      <= '0;
            lst      <= '0;
        end else begin
            if (rd.blk_ready) begin
                rd_valid <= 1'b1;
                rd_pos   <= 3'd0;
            end else if (rd_valid) begin
                rd_valid <= !rd_last;
                rd_pos   <= rd_pos + 3'd1;
            end
            vld <= {vld[2:1], rd_valid};
            lst <= {lst[2:1], rd_last};
        end
    end

    always_ff @(posedge clk) begin
        idx[1] <= rd.rd_idx;
        idx[2] <= idx[1];
        idx[3] <= idx[2];
        cur    <= rd.rd_data;
        prev   <= cur;
        case (op)
            op_add:  bfly <= cur + rd.rd_data;
            op_sub:  bfly <= prev - cur;
            default: bfly <= cur;
        endcase
    end

    assign wr.wr_en   = vld[3];
    assign wr.wr_last = lst[3];
    assign wr.wr_idx  = idx[3];
    assign wr.wr_data = bfly;

endmodule

// File: hdl/dct_stage_rotate.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// DCT stage 2
// plane rotations by the scaled cosine constants, two multipliers
// ----------------------------------------------------------------------

module dct_stage_rotate
    import dct_arith_pkg::*, dct_sched_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    dct_buf_if.reader rd,
    dct_buf_if.writer wr
);

    logic       rd_valid;
    logic [2:0] rd_pos;
    logic       rd_last;
    logic [6:1] vld;
    logic [6:1] lst;
    idx_t       idx [1:6];
    calc_t      cur;
    calc_t      opa;
    calc_t      opb;
    calc_t      cfa;
    calc_t      cfb;
    calc_t      opa_q;
    calc_t      opb_q;
    calc_t      cfa_q;
    calc_t      cfb_q;
    calc_t      prod_a;
    calc_t      prod_b;
    calc_t      rot;
    bfly_op_t   op;

    assign rd_last   = rd_pos == 3'd7;
    assign rd.rd_idx = rotate_order[rd_pos];
    assign op        = idx[5][0] ? op_sub : op_mul_add;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_pos   <= 3'd0;
            vld      <= '0;
            lst      <= '0;
        end else begin
            if (rd.blk_ready) begin
                rd_valid <= 1'b1;
                rd_pos   <= 3'd0;
            end else if (rd_valid) begin
                rd_valid <= !rd_last;
                rd_pos   <= rd_pos + 3'd1;
            end
            vld <= {vld[5:1], rd_valid};
            lst <= {lst[5:1], rd_last};
        end
    end

    always_ff @(posedge clk) begin
        idx[1] <= rotate_remap[rd.rd_idx];
        for (int i = 2; i <= 6; i++) begin
            idx[i] <= idx[i-1];
        end
        cur <= rd.rd_data;
        // even index loads a pair, odd index reuses it swapped
        if (idx[2][0] == 1'b0) begin
            opa <= cur;
            opb <= rd.rd_data;
        end else begin
            opa <= opb;
            opb <= opa;
        end
        case (idx[2])
            3'd0, 3'd1: begin
                cfa <= coef_r4;
                cfb <= coef_r4;
            end
            3'd2, 3'd3: begin
                cfa <= coef_r6;
                cfb <= coef_r2;
            end
            3'd4, 3'd7: begin
                cfa <= coef_r3;
                cfb <= -coef_r5;
            end
            default: begin
                cfa <= coef_r1;
                cfb <= coef_r7;
            end
        endcase
        opa_q  <= opa;
        opb_q  <= opb;
        cfa_q  <= cfa;
        cfb_q  <= cfb;
        prod_a <= mul_round(opa_q, cfa_q);
        prod_b <= mul_round(opb_q, cfb_q);
        rot    <= (op == op_mul_add) ? prod_a + prod_b : prod_a - prod_b;
    end

    assign wr.wr_en   = vld[6];
    assign wr.wr_last = lst[6];
    assign wr.wr_idx  = idx[6];
    assign wr.wr_data = rot;

endmodule

// File: hdl/dct_stage_final.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// DCT stage 3
// last odd-part butterflies and 1/sqrt(2) products, output scaling
// and the coefficient write to the output memory
// ----------------------------------------------------------------------

module dct_stage_final
    import dct_arith_pkg::*, dct_sched_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    dct_buf_if.reader rd,
    output logic      out_we,
    output logic      done,
    output idx_t      out_addr,
    output calc_t     out_wdata
);

    logic        rd_valid;
    logic [2:0]  rd_pos;
    logic [10:1] vld;
    idx_t        idx [1:10];
    calc_t       dat [2:7];
    calc_t       pair_a;
    calc_t       pair_b;
    calc_t       pair_a_q;
    calc_t       pair_b_q;
    calc_t       odd_add;
    calc_t       odd_sub;
    calc_t       odd_mul;
    calc_t       sub_p5;
    calc_t       sub_p1;
    calc_t       mul_p5;
    calc_t       mul_p1;
    calc_t       sel;
    calc_t       pre_scale;
    calc_t       coef_out;
    bfly_op_t    op;

    assign rd.rd_idx = final_order[rd_pos];

    always_comb begin
        if (idx[7][0] == 1'b0) begin
            op = op_pass;
        end else if (idx[7] == 3'd3 || idx[7] == 3'd5) begin
            op = op_sub;
        end else begin
            op = op_mul_add;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_pos   <= 3'd0;
            vld      <= '0;
        end else begin
            if (rd.blk_ready) begin
                rd_valid <= 1'b1;
                rd_pos   <= 3'd0;
            end else if (rd_valid) begin
                rd_valid <= rd_pos != 3'd7;
                rd_pos   <= rd_pos + 3'd1;
            end
            vld <= {vld[9:1], rd_valid};
        end
    end

    always_ff @(posedge clk) begin
        idx[1] <= final_remap[rd.rd_idx];
        for (int i = 2; i <= 10; i++) begin
            idx[i] <= idx[i-1];
        end
        dat[2] <= rd.rd_data;
        for (int i = 3; i <= 7; i++) begin
            dat[i] <= dat[i-1];
        end
        // odd pairs arrive at index 5 and index 1
        if (idx[2] == 3'd5 || idx[2] == 3'd1) begin
            pair_a <= dat[2];
            pair_b <= rd.rd_data;
        end
        pair_a_q <= pair_a;
        pair_b_q <= pair_b;
        odd_add  <= pair_a_q + pair_b_q;
        odd_sub  <= pair_a_q - pair_b_q;
        odd_mul  <= mul_round(odd_add, coef_rsqrt2);
        if (idx[5] == 3'd5) begin
            sub_p5 <= odd_sub;
        end
        if (idx[5] == 3'd1) begin
            sub_p1 <= odd_sub;
        end
        if (idx[6] == 3'd5) begin
            mul_p5 <= odd_mul;
        end
        if (idx[6] == 3'd1) begin
            mul_p1 <= odd_mul;
        end
        case (op)
            op_pass: sel <= dat[7];
            op_sub:  sel <= idx[7][1] ? sub_p1 : sub_p5;
            default: sel <= idx[7][1] ? mul_p1 - mul_p5 : mul_p1 + mul_p5;
        endcase
        pre_scale <= sel;
        coef_out  <= mul_round(pre_scale, coef_rsqrt2_half);
    end

    assign out_we    = vld[10];
    assign out_addr  = idx[10];
    assign out_wdata = coef_out;
    assign done      = vld[10] && idx[10] == 3'd7;

endmodule

// File: hdl/llm_dct_8.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Eight-point forward DCT, memory to memory
// four butterfly stages joined by three ping-pong buffers
// ----------------------------------------------------------------------

module llm_dct_8
    import dct_arith_pkg::*, dct_sched_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    output logic  ready,
    output logic  done,
    output logic  in_re,
    output idx_t  in_addr,
    input  calc_t in_rdata,
    output logic  out_we,
    output idx_t  out_addr,
    output calc_t out_wdata
);

    dct_buf_if buf0_if ();
    dct_buf_if buf1_if ();
    dct_buf_if buf2_if ();

    // ------------------------------------------------------------------
    // stages
    // ------------------------------------------------------------------

    dct_stage_fetch fetch_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .ready    (ready),
        .in_re    (in_re),
        .in_addr  (in_addr),
        .in_rdata (in_rdata),
        .wr       (buf0_if)
    );

    dct_stage_even even_i (.clk(clk), .reset(reset), .rd(buf0_if), .wr(buf1_if));

    dct_stage_rotate rotate_i (.clk(clk), .reset(reset), .rd(buf1_if), .wr(buf2_if));

    dct_stage_final final_i (
        .clk       (clk),
        .reset     (reset),
        .rd        (buf2_if),
        .out_we    (out_we),
        .done      (done),
        .out_addr  (out_addr),
        .out_wdata (out_wdata)
    );

    // ------------------------------------------------------------------
    // buffers
    // ------------------------------------------------------------------

    dct_pingpong_buf buf0_i (.clk(clk), .reset(reset), .bif(buf0_if));
    dct_pingpong_buf buf1_i (.clk(clk), .reset(reset), .bif(buf1_if));
    dct_pingpong_buf buf2_i (.clk(clk), .reset(reset), .bif(buf2_if));

endmodule

// File: verif/llm_dct_8_asserts.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// DCT core port assertions
// handshake and output write rules on the top-level ports
// ----------------------------------------------------------------------

module llm_dct_8_asserts
    import dct_sched_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic start,
    input logic ready,
    input logic in_re,
    input idx_t in_addr,
    input logic done,
    input logic out_we,
    input idx_t out_addr
);

    int fail_count = 0;

    done_with_last_write: assert property (@(posedge clk) disable iff (reset)
        done |-> out_we && out_addr == 3'd7)
        else begin
            $error("done raised without the write of coefficient 7");
            fail_count++;
        end

    no_read_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !in_re)
        else begin
            $error("input memory read while reset is held");
            fail_count++;
        end

    single_done: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            $error("done high for two cycles in a row");
            fail_count++;
        end

    // a block's first read only after an accepted start
    read_after_start: assert property (@(posedge clk) disable iff (reset)
        start && ready |=> in_re)
        else begin
            $error("accepted start not followed by a read");
            fail_count++;
        end

    start_before_read: assert property (@(posedge clk) disable iff (reset)
        in_re && in_addr == 3'd0 |-> $past(start && ready))
        else begin
            $error("block read began without an accepted start");
            fail_count++;
        end

endmodule

// File: verif/tb_llm_dct_8.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Testbench for the eight-point DCT core
// input and output memory models, a real-valued reference DCT and
// directed tests on constant, random and back-to-back blocks
// ----------------------------------------------------------------------

module tb_llm_dct_8
    import dct_arith_pkg::*, dct_sched_pkg::*;
();

    localparam int  max_blocks     = 16;
    localparam int  n_random       = 6;
    localparam int  n_b2b          = 4;
    localparam int  reset_cycles   = 16;
    localparam int  block_cycles   = 80;
    localparam int  timeout_cycles = reset_cycles + (1 + n_random + n_b2b) * block_cycles + 200;
    localparam int  tol            = 8;
    localparam int  const_level    = 1000;
    localparam real pi             = 3.14159265358979;

    logic  clk = 1'b0;
    logic  reset;
    logic  start;
    logic  ready;
    logic  done;
    logic  in_re;
    idx_t  in_addr;
    calc_t in_rdata;
    logic  out_we;
    idx_t  out_addr;
    calc_t out_wdata;

    int          blk_x    [max_blocks][8];
    int          out_val  [max_blocks][8];
    logic [7:0]  rd_mask  [max_blocks] = '{default: 8'h00};
    logic [7:0]  out_mask [max_blocks] = '{default: 8'h00};
    int          rd_count    = 0;
    int          out_count   = 0;
    int          done_count  = 0;
    int          n_issued    = 0;
    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run   = 0;
    int          tests_failed = 0;
    logic        rdata_due   = 1'b0;
    calc_t       next_rdata;
    logic [31:0] lfsr_state  = 32'hc1b3;

    always #5 clk = !clk;

    llm_dct_8 llm_dct_8_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .ready     (ready),
        .done      (done),
        .in_re     (in_re),
        .in_addr   (in_addr),
        .in_rdata  (in_rdata),
        .out_we    (out_we),
        .out_addr  (out_addr),
        .out_wdata (out_wdata)
    );

    bind llm_dct_8 llm_dct_8_asserts llm_dct_8_asserts_i (
        .clk(clk), .reset(reset), .start(start), .ready(ready), .in_re(in_re),
        .in_addr(in_addr), .done(done), .out_we(out_we), .out_addr(out_addr)
    );

    // ------------------------------------------------------------------
    // memory models, sampled mid-cycle
    // ------------------------------------------------------------------

    always @(negedge clk) begin
        int b;
        if (!reset && in_re) begin
            b = rd_count >> 3;
            if (b < max_blocks) begin
                rd_mask[b] = rd_mask[b] | (8'd1 << in_addr);
                next_rdata = calc_t'(blk_x[b][in_addr]);
            end
            rd_count++;
            rdata_due = 1'b1;
        end
        if (!reset && out_we) begin
            b = out_count >> 3;
            if (b < max_blocks) begin
                out_mask[b]          = out_mask[b] | (8'd1 << out_addr);
                out_val[b][out_addr] = int'(out_wdata);
            end
            out_count++;
            if (done) begin
                done_count++;
            end
        end
    end

    // synchronous read data, one cycle after the address
    always @(posedge clk) begin
        #1;
        if (rdata_due) begin
            in_rdata  = next_rdata;
            rdata_due = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int round_to_int(input real r);
        return $rtoi(r >= 0.0 ? r + 0.5 : r - 0.5);
    endfunction

    // orthonormal DCT-II of one stored input block
    function automatic int ref_coef(input int b, input int k);
        real acc;
        real scale;
        acc = 0.0;
        for (int n = 0; n < 8; n++) begin
            acc = acc + real'(blk_x[b][n]) * $cos(real'((2 * n + 1) * k) * pi / 16.0);
        end
        scale = (k == 0) ? 0.5 / $sqrt(2.0) : 0.5;
        return round_to_int(acc * scale);
    endfunction

    task automatic check_close(input string name, input int got, input int expected,
                               input int margin);
        int diff;
        diff = got - expected;
        check_count++;
        if (diff > margin || diff < -margin) begin
            $display("ERR %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (error_count > err0) begin
            tests_failed++;
        end
        $display("%-20s finished, %0d errors", name, error_count - err0);
    endtask

    task automatic issue_block();
        start = 1'b1;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        start = 1'b0;
        n_issued++;
    endtask

    task automatic wait_for_done(input int target);
        @(posedge clk);
        while (done_count < target) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic compare_block(input int b);
        check_close("out_addr coverage", int'(out_mask[b]), 255, 0);
        for (int k = 0; k < 8; k++) begin
            check_close($sformatf("out_wdata[%0d]", k), out_val[b][k], ref_coef(b, k), tol);
        end
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------

    task automatic after_reset();
        int err0;
        err0 = error_count;
        check_close("ready", int'(ready), 1, 0);
        check_close("in_re", int'(in_re), 0, 0);
        check_close("out_we", int'(out_we), 0, 0);
        check_close("done", int'(done), 0, 0);
        report_test("after_reset", err0);
    endtask

    task automatic constant_block();
        int err0;
        int b;
        err0 = error_count;
        b = n_issued;
        for (int i = 0; i < 8; i++) begin
            blk_x[b][i] = const_level;
        end
        issue_block();
        wait_for_done(b + 1);
        compare_block(b);
        check_close("out_wdata[0]", out_val[b][0],
                    round_to_int($sqrt(8.0) * real'(const_level)), tol);
        report_test("constant_block", err0);
    endtask

    task automatic random_blocks();
        int err0;
        int b;
        err0 = error_count;
        for (int j = 0; j < n_random; j++) begin
            b = n_issued;
            for (int i = 0; i < 8; i++) begin
                blk_x[b][i] = take_bits(13) - 4096;
            end
            issue_block();
            wait_for_done(b + 1);
            compare_block(b);
        end
        report_test("random_blocks", err0);
    endtask

    task automatic back_to_back();
        int err0;
        int first;
        err0 = error_count;
        first = n_issued;
        for (int j = 0; j < n_b2b; j++) begin
            for (int i = 0; i < 8; i++) begin
                blk_x[first + j][i] = take_bits(13) - 4096;
            end
        end
        // start stays high so each block follows the last without a gap
        for (int j = 0; j < n_b2b; j++) begin
            issue_block();
        end
        wait_for_done(first + n_b2b);
        // each done pulse closes a block of eight writes
        check_close("out_we count", out_count, 8 * (first + n_b2b), 0);
        for (int j = 0; j < n_b2b; j++) begin
            compare_block(first + j);
        end
        report_test("back_to_back", err0);
    endtask

    task automatic input_addresses();
        int err0;
        err0 = error_count;
        check_close("in_re count", rd_count, 8 * n_issued, 0);
        for (int b = 0; b < n_issued; b++) begin
            check_close("in_addr coverage", int'(rd_mask[b]), 255, 0);
        end
        report_test("input_addresses", err0);
    endtask

    task automatic assertion_failures();
        int err0;
        int n_fail;
        err0 = error_count;
        n_fail = llm_dct_8_i.llm_dct_8_asserts_i.fail_count;
        check_count++;
        if (n_fail != 0) begin
            $display("bound assertions failed %0d times during the run", n_fail);
            error_count++;
        end
        report_test("assertion_failures", err0);
    endtask

    initial begin
        reset    = 1'b1;
        start    = 1'b0;
        in_rdata = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        after_reset();
        constant_block();
        random_blocks();
        back_to_back();
        input_addresses();
        assertion_failures();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/dct_arith_pkg.sv
hdl/dct_sched_pkg.sv
hdl/dct_buf_if.sv
hdl/dct_pingpong_buf.sv
hdl/dct_stage_fetch.sv
hdl/dct_stage_even.sv
hdl/dct_stage_rotate.sv
hdl/dct_stage_final.sv
hdl/llm_dct_8.sv
verif/llm_dct_8_asserts.sv
verif/tb_llm_dct_8.sv

// File: Makefile
# Verilator build and run for the eight-point DCT testbench

VERILATOR ?= verilator
TOP       ?= tb_llm_dct_8
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
